// ==== design/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath widths
`define CPU_XLEN         32
`define CPU_REG_ADDR_W   5
`define CPU_OPCODE_W     7
`define CPU_FUNCT3_W     3

// first fetch address out of reset
`define CPU_RESET_PC     32'h0000_0000

// major opcodes, instr[6:0]
`define CPU_OP_RTYPE     7'b0110011
`define CPU_OP_ITYPE     7'b0010011
`define CPU_OP_LOAD      7'b0000011
`define CPU_OP_STORE     7'b0100011
`define CPU_OP_BRANCH    7'b1100011
`define CPU_OP_JAL       7'b1101111
`define CPU_OP_JALR      7'b1100111
`define CPU_OP_LUI       7'b0110111

// funct7 for sub on r-type
`define CPU_F7_SUB       7'b0100000

`endif

// ==== design/cpu_pkg.sv ====
`include "cpu_settings.svh"

package cpu_pkg;

    // data word, address or raw instruction
    typedef logic [`CPU_XLEN-1:0] word_t;

    // register index x0..x31
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [`CPU_OPCODE_W-1:0] opcode_t;
    typedef logic [`CPU_FUNCT3_W-1:0] funct3_t;

    // sequencer states, one instruction in flight
    typedef enum logic [1:0] {
        FETCH   = 2'd0,  // imem request
        EXECUTE = 2'd1,  // decode, alu, store, retire
        MEMORY  = 2'd2   // load data write-back
    } core_state_t;

endpackage

// ==== design/decode_if.sv ====
`timescale 1ns/1ns

// decoded fields of the held instruction
interface decode_if;

    cpu_pkg::opcode_t   opcode;
    cpu_pkg::funct3_t   funct3;
    logic               sub_sel;    // r-type sub only
    cpu_pkg::reg_addr_t rs1;
    cpu_pkg::reg_addr_t rs2;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::word_t     imm;        // sign-extended, u-type pre-shifted
    logic               use_imm;    // operand b from imm
    logic               writes_rd;  // already cleared for rd == x0
    logic               is_load;
    logic               is_store;
    logic               is_branch;
    logic               is_jal;
    logic               is_jalr;

    modport producer (
        output opcode, funct3, sub_sel, rs1, rs2, rd, imm, use_imm, writes_rd,
        output is_load, is_store, is_branch, is_jal, is_jalr
    );

    modport consumer (
        input opcode, funct3, sub_sel, rs1, rs2, rd, imm, use_imm, writes_rd,
        input is_load, is_store, is_branch, is_jal, is_jalr
    );

endinterface

// ==== design/instr_decoder.sv ====
`timescale 1ns/1ns
`include "cpu_settings.svh"

module instr_decoder (
    input  cpu_pkg::word_t instr_i,
    decode_if.producer     dec
);

    cpu_pkg::word_t imm_i_type;
    cpu_pkg::word_t imm_s_type;
    cpu_pkg::word_t imm_b_type;
    cpu_pkg::word_t imm_j_type;
    cpu_pkg::word_t imm_u_type;
    logic           rd_used;

    // immediate formats, all sign-extended from bit 31
    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};

    always_comb begin
        dec.opcode    = instr_i[6:0];
        dec.funct3    = '0;
        dec.sub_sel   = 1'b0;
        dec.rs1       = '0;
        dec.rs2       = '0;
        dec.rd        = '0;
        dec.imm       = '0;
        dec.use_imm   = 1'b0;
        dec.is_load   = 1'b0;
        dec.is_store  = 1'b0;
        dec.is_branch = 1'b0;
        dec.is_jal    = 1'b0;
        dec.is_jalr   = 1'b0;
        rd_used       = 1'b0;
        case (instr_i[6:0])
            `CPU_OP_RTYPE: begin
                dec.funct3  = instr_i[14:12];
                dec.rs1     = instr_i[19:15];
                dec.rs2     = instr_i[24:20];
                dec.rd      = instr_i[11:7];
                dec.sub_sel = (instr_i[31:25] == `CPU_F7_SUB);
                rd_used     = 1'b1;
            end
            `CPU_OP_ITYPE, `CPU_OP_LOAD, `CPU_OP_JALR: begin
                dec.funct3  = instr_i[14:12];
                dec.rs1     = instr_i[19:15];
                dec.rd      = instr_i[11:7];
                dec.imm     = imm_i_type;
                dec.use_imm = 1'b1;
                dec.is_load = (instr_i[6:0] == `CPU_OP_LOAD);
                dec.is_jalr = (instr_i[6:0] == `CPU_OP_JALR);
                rd_used     = 1'b1;
            end
            `CPU_OP_STORE: begin
                dec.funct3   = instr_i[14:12];
                dec.rs1      = instr_i[19:15];
                dec.rs2      = instr_i[24:20];  // store data
                dec.imm      = imm_s_type;
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
            end
            `CPU_OP_BRANCH: begin
                dec.funct3    = instr_i[14:12];
                dec.rs1       = instr_i[19:15];
                dec.rs2       = instr_i[24:20];
                dec.imm       = imm_b_type;  // target offset, compare uses rs2
                dec.is_branch = 1'b1;
            end
            `CPU_OP_JAL: begin
                dec.rd      = instr_i[11:7];
                dec.imm     = imm_j_type;
                dec.use_imm = 1'b1;
                dec.is_jal  = 1'b1;
                rd_used     = 1'b1;
            end
            `CPU_OP_LUI: begin
                dec.rd      = instr_i[11:7];
                dec.imm     = imm_u_type;
                dec.use_imm = 1'b1;
                rd_used     = 1'b1;
            end
            default: ;  // unknown opcode runs as a nop
        endcase
    end

    // x0 never written
    assign dec.writes_rd = rd_used & (instr_i[11:7] != '0);

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ns

module register_file (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t rs1_i,
    input  cpu_pkg::reg_addr_t rs2_i,
    input  cpu_pkg::reg_addr_t rd_i,
    input  logic               we_i,
    input  cpu_pkg::word_t     wdata_i,
    output cpu_pkg::word_t     rs1_data_o,
    output cpu_pkg::word_t     rs2_data_o
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // x0 stays at its reset value, write above skips it
    // reads are combinational, no bypass needed with one instruction in flight
    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

endmodule

// ==== design/alu_branch.sv ====
`timescale 1ns/1ns
`include "cpu_settings.svh"

module alu_branch (
    decode_if.consumer     dec,
    input  cpu_pkg::word_t pc_i,
    input  cpu_pkg::word_t rs1_data_i,
    input  cpu_pkg::word_t rs2_data_i,
    output cpu_pkg::word_t result_o,
    output cpu_pkg::word_t next_pc_o,
    output logic           taken_o
);

    cpu_pkg::word_t op_b;
    cpu_pkg::word_t sum;
    cpu_pkg::word_t pc_plus4;
    cpu_pkg::word_t alu_res;
    logic           cond;

    assign op_b     = dec.use_imm ? dec.imm : rs2_data_i;
    assign sum      = rs1_data_i + op_b;  // also load/store address and jalr target
    assign pc_plus4 = pc_i + cpu_pkg::word_t'(4);

    // r-type and i-type ops
    always_comb begin
        case (dec.funct3)
            3'b000, 3'b010: alu_res = dec.sub_sel ? (rs1_data_i - op_b) : sum;
            3'b100:         alu_res = rs1_data_i ^ op_b;
            3'b110:         alu_res = rs1_data_i | op_b;
            3'b111:         alu_res = rs1_data_i & op_b;
            3'b001:         alu_res = rs1_data_i << op_b[4:0];
            3'b101:         alu_res = rs1_data_i >> op_b[4:0];  // logical only
            default:        alu_res = '0;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            `CPU_OP_RTYPE, `CPU_OP_ITYPE: result_o = alu_res;
            `CPU_OP_LOAD, `CPU_OP_STORE:  result_o = sum;
            `CPU_OP_LUI:                  result_o = op_b;
            `CPU_OP_JAL, `CPU_OP_JALR:    result_o = pc_plus4;  // link value
            default:                      result_o = '0;
        endcase
    end

    // branch compare, both less-than forms unsigned
    always_comb begin
        case (dec.funct3)
            3'b000:  cond = (rs1_data_i == rs2_data_i);
            3'b001:  cond = (rs1_data_i != rs2_data_i);
            3'b100:  cond = (rs1_data_i < rs2_data_i);
            3'b101:  cond = (rs1_data_i >= rs2_data_i);
            default: cond = 1'b0;
        endcase
    end

    assign taken_o = (dec.is_branch & cond) | dec.is_jal | dec.is_jalr;

    always_comb begin
        if (dec.is_jalr) begin
            next_pc_o = {sum[31:1], 1'b0};
        end else if (taken_o) begin
            next_pc_o = pc_i + dec.imm;  // taken branch or jal
        end else begin
            next_pc_o = pc_plus4;
        end
    end

endmodule

// ==== design/core_sequencer.sv ====
`timescale 1ns/1ns
`include "cpu_settings.svh"

module core_sequencer (
    input  logic           clk,
    input  logic           rst,
    decode_if.consumer     dec,
    input  cpu_pkg::word_t imem_data_i,
    input  cpu_pkg::word_t dmem_rdata_i,
    input  cpu_pkg::word_t alu_result_i,
    input  cpu_pkg::word_t next_pc_i,
    input  cpu_pkg::word_t rs2_data_i,
    output cpu_pkg::word_t instr_o,
    output cpu_pkg::word_t pc_o,
    output logic           rd_we_o,
    output cpu_pkg::word_t rd_wdata_o,
    output logic           imem_req_o,
    output logic           dmem_re_o,
    output logic           dmem_we_o,
    output cpu_pkg::word_t dmem_addr_o,
    output cpu_pkg::word_t dmem_wdata_o
);

    cpu_pkg::core_state_t state;
    cpu_pkg::core_state_t state_nxt;
    cpu_pkg::word_t       pc_q;
    cpu_pkg::word_t       ir_q;
    logic                 in_exec;
    logic                 in_mem;
    logic                 retire;  // last cycle of the instruction

    assign in_exec = (state == cpu_pkg::EXECUTE);
    assign in_mem  = (state == cpu_pkg::MEMORY);

    // loads retire from MEMORY, everything else from EXECUTE
    assign retire = (in_exec & ~dec.is_load) | in_mem;

    always_comb begin
        case (state)
            cpu_pkg::FETCH:   state_nxt = cpu_pkg::EXECUTE;
            cpu_pkg::EXECUTE: state_nxt = dec.is_load ? cpu_pkg::MEMORY : cpu_pkg::FETCH;
            cpu_pkg::MEMORY:  state_nxt = cpu_pkg::FETCH;
            default:          state_nxt = cpu_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cpu_pkg::FETCH;
            pc_q  <= `CPU_RESET_PC;
            ir_q  <= '0;  // decodes as a nop
        end else begin
            state <= state_nxt;
            if (state == cpu_pkg::FETCH) begin
                ir_q <= imem_data_i;  // memory answered during FETCH
            end
            if (retire) begin
                pc_q <= next_pc_i;
            end
        end
    end

    assign instr_o = ir_q;
    assign pc_o    = pc_q;

    // bus strobes, one cycle each
    assign imem_req_o   = (state == cpu_pkg::FETCH);
    assign dmem_re_o    = in_exec & dec.is_load;
    assign dmem_we_o    = in_exec & dec.is_store;
    assign dmem_addr_o  = alu_result_i;  // rs1 + imm for load/store
    assign dmem_wdata_o = rs2_data_i;

    // write-back, load data only in MEMORY
    assign rd_we_o    = dec.writes_rd & retire;
    assign rd_wdata_o = in_mem ? dmem_rdata_i : alu_result_i;

endmodule

// ==== design/rv_core_top.sv ====
`timescale 1ns/1ns

module rv_core_top (
    input  logic           clk,
    input  logic           rst,
    output logic           imem_req_o,
    output cpu_pkg::word_t imem_addr_o,
    input  cpu_pkg::word_t imem_data_i,
    output logic           dmem_re_o,
    output logic           dmem_we_o,
    output cpu_pkg::word_t dmem_addr_o,
    output cpu_pkg::word_t dmem_wdata_o,
    input  cpu_pkg::word_t dmem_rdata_i
);

    cpu_pkg::word_t instr;
    cpu_pkg::word_t pc;
    cpu_pkg::word_t rs1_data;
    cpu_pkg::word_t rs2_data;
    cpu_pkg::word_t alu_result;
    cpu_pkg::word_t next_pc;
    cpu_pkg::word_t rd_wdata;
    logic           rd_we;

    decode_if dec_bus ();

    instr_decoder u_decoder (
        .instr_i (instr),
        .dec     (dec_bus)
    );

    register_file u_regfile (
        .clk        (clk),
        .rst        (rst),
        .rs1_i      (dec_bus.rs1),
        .rs2_i      (dec_bus.rs2),
        .rd_i       (dec_bus.rd),
        .we_i       (rd_we),
        .wdata_i    (rd_wdata),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    alu_branch u_alu (
        .dec        (dec_bus),
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .result_o   (alu_result),
        .next_pc_o  (next_pc),
        .taken_o    ()
    );

    core_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .dec          (dec_bus),
        .imem_data_i  (imem_data_i),
        .dmem_rdata_i (dmem_rdata_i),
        .alu_result_i (alu_result),
        .next_pc_i    (next_pc),
        .rs2_data_i   (rs2_data),
        .instr_o      (instr),
        .pc_o         (pc),
        .rd_we_o      (rd_we),
        .rd_wdata_o   (rd_wdata),
        .imem_req_o   (imem_req_o),
        .dmem_re_o    (dmem_re_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o)
    );

    assign imem_addr_o = pc;  // fetch address is the current pc

endmodule

// ==== dv/rv_core_assert.sv ====
`timescale 1ns/1ns

module rv_core_assert (
    input logic                 clk,
    input logic                 rst,
    input cpu_pkg::core_state_t state_i,
    input logic                 imem_req_i,
    input logic                 dmem_re_i,
    input logic                 dmem_we_i
);

    assert property (@(posedge clk) disable iff (rst) !(dmem_re_i && dmem_we_i))
        else $error("data read and write strobes high in the same cycle");

    // data strobes only while executing
    assert property (@(posedge clk) disable iff (rst)
        (dmem_re_i || dmem_we_i) |-> (state_i == cpu_pkg::EXECUTE))
        else $error("data strobe outside EXECUTE");

    assert property (@(posedge clk) disable iff (rst)
        dmem_re_i |=> (state_i == cpu_pkg::MEMORY))  // load goes on to MEMORY
        else $error("load in EXECUTE not followed by MEMORY");

    assert property (@(posedge clk) disable iff (rst)
        imem_req_i |-> (state_i == cpu_pkg::FETCH))
        else $error("instruction request outside FETCH");

endmodule

bind core_sequencer rv_core_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .state_i    (state),
    .imem_req_i (imem_req_o),
    .dmem_re_i  (dmem_re_o),
    .dmem_we_i  (dmem_we_o)
);

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/1ns
`include "cpu_settings.svh"

module rv_core_tb;

    localparam int WAIT_LIMIT = 20;  // cycles allowed between two bus events
    localparam int SHAMT      = 5;
    // operands set up by the first two addi
    localparam cpu_pkg::word_t OP_A = 32'h0000_0123;
    localparam cpu_pkg::word_t OP_B = 32'hffff_fff9;  // -7

    logic           clk;
    logic           rst;
    logic           imem_req_o;
    cpu_pkg::word_t imem_addr_o;
    cpu_pkg::word_t imem_data_i;
    logic           dmem_re_o;
    logic           dmem_we_o;
    cpu_pkg::word_t dmem_addr_o;
    cpu_pkg::word_t dmem_wdata_o;
    cpu_pkg::word_t dmem_rdata_i;

    cpu_pkg::word_t prog [64];
    cpu_pkg::word_t dmem [16];
    cpu_pkg::word_t fetch_q [$];       // expected fetch order
    cpu_pkg::word_t store_addr_q [$];
    cpu_pkg::word_t store_data_q [$];
    integer         seed;
    int             wait_cnt;
    int             n_fetched;

    rv_core_top DUT (.*);

    // instruction encoders, standard rv32 field layout
    function automatic cpu_pkg::word_t rtype(input bit sub, input int rd, f3, rs1, rs2);
        return {(sub ? `CPU_F7_SUB : 7'b0), rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `CPU_OP_RTYPE};
    endfunction

    function automatic cpu_pkg::word_t itype(input logic [6:0] op, input int rd, f3, rs1, imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic cpu_pkg::word_t store_word(input int src, base, off);
        return {off[11:5], src[4:0], base[4:0], 3'b010, off[4:0], `CPU_OP_STORE};
    endfunction

    function automatic cpu_pkg::word_t branch_word(input int f3, rs1, rs2, off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                `CPU_OP_BRANCH};
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_fetch_addr(input cpu_pkg::word_t got, input cpu_pkg::word_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %0t ns: fetch address %h, expected %h", $time, got, exp));
    endtask

    task automatic check_store_addr(input cpu_pkg::word_t got, input cpu_pkg::word_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %0t ns: store address %h, expected %h", $time, got, exp));
    endtask

    task automatic check_store_data(input cpu_pkg::word_t got, input cpu_pkg::word_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %0t ns: store data %h, expected %h", $time, got, exp));
    endtask

    // program rows are listed in execution order
    task automatic place_instr(input int pc, input cpu_pkg::word_t instr);
        prog[pc / 4] = instr;
        fetch_q.push_back(cpu_pkg::word_t'(pc));
    endtask

    // sw src, off(x0) with its expected bus write
    task automatic put_store(input int pc, input int src, input int off,
                             input cpu_pkg::word_t exp);
        place_instr(pc, store_word(src, 0, off));
        store_addr_q.push_back(cpu_pkg::word_t'(off));
        store_data_q.push_back(exp);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory models answer on the falling edge
    always @(negedge clk) begin
        if (imem_req_o) imem_data_i = prog[imem_addr_o[7:2]];
        if (dmem_re_o) dmem_rdata_i = dmem[dmem_addr_o[5:2]];
        if (dmem_we_o) dmem[dmem_addr_o[5:2]] = dmem_wdata_o;
    end

    initial begin
        rst          = 1'b1;
        imem_data_i  = '0;
        dmem_rdata_i = '0;
        n_fetched    = 0;
        seed         = 32'h1f61_1978;
        for (int i = 0; i < 16; i++) dmem[i] = $random(seed);
        for (int i = 0; i < 64; i++) prog[i] = '0;  // zero word runs as a nop

        place_instr('h00, itype(`CPU_OP_ITYPE, 1, 0, 0, 'h123));  // addi x1
        place_instr('h04, itype(`CPU_OP_ITYPE, 2, 0, 0, -7));     // addi x2
        place_instr('h08, rtype(1'b0, 3, 0, 1, 2));               // add
        put_store('h0c, 3, 'h00, OP_A + OP_B);
        place_instr('h10, rtype(1'b1, 4, 0, 1, 2));               // sub
        put_store('h14, 4, 'h04, OP_A - OP_B);
        place_instr('h18, rtype(1'b0, 5, 4, 1, 2));               // xor
        put_store('h1c, 5, 'h08, OP_A ^ OP_B);
        place_instr('h20, rtype(1'b0, 6, 6, 1, 2));               // or
        put_store('h24, 6, 'h0c, OP_A | OP_B);
        place_instr('h28, rtype(1'b0, 7, 7, 1, 2));               // and
        put_store('h2c, 7, 'h10, OP_A & OP_B);
        place_instr('h30, itype(`CPU_OP_ITYPE, 8, 0, 0, SHAMT));
        place_instr('h34, rtype(1'b0, 9, 1, 1, 8));               // sll
        put_store('h38, 9, 'h14, OP_A << SHAMT);
        place_instr('h3c, rtype(1'b0, 10, 5, 2, 8));              // srl
        put_store('h40, 10, 'h18, OP_B >> SHAMT);
        place_instr('h44, {20'habcde, 5'd11, `CPU_OP_LUI});       // lui x11
        put_store('h48, 11, 'h1c, {20'habcde, 12'h000});
        place_instr('h4c, itype(`CPU_OP_ITYPE, 0, 0, 1, 1));      // addi x0, must stay zero
        put_store('h50, 0, 'h24, '0);
        place_instr('h54, itype(`CPU_OP_LOAD, 12, 2, 0, 'h20));   // lw x12, 0x20(x0)
        put_store('h58, 12, 'h28, dmem[8]);
        place_instr('h5c, branch_word(0, 1, 2, 8));               // beq not taken
        place_instr('h60, branch_word(0, 1, 1, 8));               // beq taken
        place_instr('h68, branch_word(1, 1, 1, 8));               // bne not taken
        place_instr('h6c, branch_word(1, 1, 2, 8));               // bne taken
        place_instr('h74, branch_word(4, 2, 1, 8));               // unsigned lt, not taken
        place_instr('h78, branch_word(4, 1, 2, 8));               // unsigned lt, taken
        place_instr('h80, branch_word(5, 1, 2, 8));               // unsigned ge, not taken
        place_instr('h84, branch_word(5, 2, 1, 8));               // unsigned ge, taken
        place_instr('h8c, {1'b0, 10'd6, 1'b0, 8'd0, 5'd13, `CPU_OP_JAL});  // jal x13, +12
        put_store('h98, 13, 'h2c, 32'h8c + 32'd4);
        place_instr('h9c, itype(`CPU_OP_ITYPE, 14, 0, 0, 'hb0));
        place_instr('ha0, itype(`CPU_OP_JALR, 15, 0, 14, 5));    // target 0xb5, bit 0 cleared
        put_store('hb4, 15, 'h30, 32'ha0 + 32'd4);
        fetch_q.push_back(32'hb8);  // fetch after the last store

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (fetch_q.size() > 0 || store_addr_q.size() > 0) begin
            wait_cnt = 0;
            while (!imem_req_o && !dmem_we_o) begin
                @(negedge clk);
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT)
                    abort_run("timeout while waiting for a fetch request or a store strobe");
            end
            if (imem_req_o) begin
                if (fetch_q.size() == 0)
                    abort_run("fetch request seen after the last expected fetch");
                check_fetch_addr(imem_addr_o, fetch_q.pop_front());
                n_fetched++;
            end else begin
                if (n_fetched == 0 || store_addr_q.size() == 0)
                    abort_run("store strobe seen where no store was expected");
                check_store_addr(dmem_addr_o, store_addr_q.pop_front());
                check_store_data(dmem_wdata_o, store_data_q.pop_front());
            end
            @(negedge clk);
        end

        $display("No errors");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+design
design/cpu_pkg.sv
design/decode_if.sv
design/instr_decoder.sv
design/register_file.sv
design/alu_branch.sv
design/core_sequencer.sv
design/rv_core_top.sv
dv/rv_core_assert.sv
dv/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator and run it
# exit status is nonzero when the build fails or the simulation stops on $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module rv_core_tb -f sources.f -o rv_core_sim &&
./obj_dir/rv_core_sim ||
{ echo "build or simulation failed"; exit 1; }
